// ==== Bender.yml ====
package:
  name: bringup_boundary

sources:
  - files:
      - hw/bringup_pkg.sv
      - hw/pulse.sv
      - hw/bringup_driver.sv
      - hw/bringup_sensor.sv
      - hw/uart_tx.sv
      - hw/bringup_scanner.sv
      - hw/bringup_boundary.sv
  - target: test
    files:
      - verification/uart_rx_model.sv
      - verification/tb_bringup_boundary.sv

// ==== hw/bringup_boundary.sv ====
// Top level of the boundary checker; drives a test pin and reports sensed pin activity over UART
`timescale 1ns/1ps

module bringup_boundary #(
	parameter int NUM_PINS        = 16,
	parameter int DRIVE_CLOCKS    = 6000,    // 1 kHz at 12 MHz
	parameter int DEC_CLOCKS      = 12000,
	parameter int SCAN_CLOCKS     = 1200000, // 10 Hz
	parameter int CLOCKS_PER_BAUD = 104      // 115200 baud
) (
	input  logic                clock,
	input  logic                rst_n_i,
	input  logic [NUM_PINS-1:0] pins_i,
	output logic                drive_o,
	output logic                uart_tx_o
);

	import bringup_pkg::*;

	logic                dec;
	logic                scan;
	logic [NUM_PINS-1:0] sensed;
	uart_req_t           uart_req;
	logic                uart_busy;

	bringup_driver #(
		.DRIVE_CLOCKS(DRIVE_CLOCKS)
	) bringup_driver0 (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.pin_o   (drive_o)
	);

	// Decay must be slower than the driver so a live pin never drops out
	pulse #(
		.CLOCKS_PER_PULSE(DEC_CLOCKS)
	) pulse_dec (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.pulse_o (dec)
	);

	pulse #(
		.CLOCKS_PER_PULSE(SCAN_CLOCKS)
	) pulse_scan (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.pulse_o (scan)
	);

	for (genvar i = 0; i < NUM_PINS; i++) begin : g_sensor
		bringup_sensor sensor (
			.clock    (clock),
			.rst_n_i  (rst_n_i),
			.pin_i    (pins_i[i]),
			.dec_i    (dec),
			.sensed_o (sensed[i])
		);
	end

	bringup_scanner #(
		.NUM_PINS(NUM_PINS)
	) bringup_scanner0 (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.scan_i  (scan),
		.state_i (sensed),
		.busy_i  (uart_busy),
		.req_o   (uart_req)
	);

	uart_tx #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) uart_tx0 (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.req_i   (uart_req),
		.busy_o  (uart_busy),
		.tx_o    (uart_tx_o)
	);

endmodule

// ==== hw/bringup_driver.sv ====
// Known square wave for the board; toggles pin_o every DRIVE_CLOCKS clocks
`timescale 1ns/1ps

module bringup_driver #(
	parameter int DRIVE_CLOCKS = 6000
) (
	input  logic clock,
	input  logic rst_n_i,
	output logic pin_o
);

	localparam int CNT_W = (DRIVE_CLOCKS > 1) ? $clog2(DRIVE_CLOCKS) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DRIVE_CLOCKS - 1);

	logic [CNT_W-1:0] count;

	// Half period divider
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count <= RELOAD;
			pin_o <= 1'b0;
		end else if (count == '0) begin
			count <= RELOAD;
			pin_o <= ~pin_o;
		end else begin
			count <= count - CNT_W'(1);
		end
	end

endmodule

// ==== hw/bringup_pkg.sv ====
// Shared types and constants for the boundary checker; imported by the scanner, UART and top level
package bringup_pkg;

	// One character on the serial line
	typedef logic [7:0] uart_byte_t;

	// Write strobe plus payload, scanner to UART
	typedef struct packed {
		logic       write;
		uart_byte_t data;
	} uart_req_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_SEND,
		SCAN_WAIT
	} scan_state_e;

	// Report line characters
	localparam uart_byte_t CHAR_ZERO = 8'h30;
	localparam uart_byte_t CHAR_ONE  = 8'h31;
	localparam uart_byte_t CHAR_CR   = 8'h0D;
	localparam uart_byte_t CHAR_LF   = 8'h0A;

	// Sensor activity hold, in decay pulses
	localparam int                      SENSE_HOLD_W = 2;
	localparam logic [SENSE_HOLD_W-1:0] SENSE_HOLD   = 2'd3;

endpackage

// ==== hw/bringup_scanner.sv ====
// Snapshots the sensor vector on each scan pulse and sends it as an ASCII line over the UART
`timescale 1ns/1ps

module bringup_scanner #(
	parameter int NUM_PINS = 16
) (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic                   scan_i,
	input  logic [NUM_PINS-1:0]    state_i,
	input  logic                   busy_i,
	output bringup_pkg::uart_req_t req_o
);

	import bringup_pkg::*;

	localparam int IDX_W = $clog2(NUM_PINS + 2);
	localparam logic [IDX_W-1:0] IDX_CR = IDX_W'(NUM_PINS);
	localparam logic [IDX_W-1:0] IDX_LF = IDX_W'(NUM_PINS + 1);

	scan_state_e         state;
	logic [NUM_PINS-1:0] snap;
	logic [IDX_W-1:0]    byte_idx;
	logic                write_q;
	uart_byte_t          data_q;
	uart_byte_t          next_char;
	logic                send;

	// One byte per pin, pin 0 first, then CR LF
	always_comb begin
		if (byte_idx == IDX_LF)
			next_char = CHAR_LF;
		else if (byte_idx == IDX_CR)
			next_char = CHAR_CR;
		else
			next_char = snap[0] ? CHAR_ONE : CHAR_ZERO;
	end

	assign send = (state == SCAN_SEND) && !busy_i;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= SCAN_IDLE;
			byte_idx <= '0;
			write_q  <= 1'b0;
		end else begin
			write_q <= 1'b0;
			case (state)
				SCAN_IDLE: begin
					if (scan_i) begin
						byte_idx <= '0;
						state    <= SCAN_SEND;
					end
				end
				SCAN_SEND: begin
					if (!busy_i) begin
						write_q <= 1'b1;
						state   <= SCAN_WAIT;
					end
				end
				SCAN_WAIT: begin
					// UART takes the byte on this edge, busy is valid from here on
					if (byte_idx == IDX_LF) begin
						state <= SCAN_IDLE;
					end else begin
						byte_idx <= byte_idx + IDX_W'(1);
						state    <= SCAN_SEND;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	// Snapshot shifts down one pin per sent byte
	always_ff @(posedge clock) begin
		if (state == SCAN_IDLE && scan_i)
			snap <= state_i;
		else if (send && byte_idx < IDX_CR)
			snap <= snap >> 1;
	end

	always_ff @(posedge clock) begin
		if (send)
			data_q <= next_char;
	end

	assign req_o = '{write: write_q, data: data_q};

endmodule

// ==== hw/bringup_sensor.sv ====
// Activity detector for one sensed pin; sensed_o stays high while the pin has toggled recently
`timescale 1ns/1ps

module bringup_sensor (
	input  logic clock,
	input  logic rst_n_i,
	input  logic pin_i,
	input  logic dec_i,
	output logic sensed_o
);

	import bringup_pkg::*;

	logic                    sync_meta;
	logic                    sync_pin;
	logic                    prev_pin;
	logic                    pin_edge;
	logic [SENSE_HOLD_W-1:0] hold;

	// Two stage synchronizer, then last sample for edge compare
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_meta <= 1'b0;
			sync_pin  <= 1'b0;
			prev_pin  <= 1'b0;
		end else begin
			sync_meta <= pin_i;
			sync_pin  <= sync_meta;
			prev_pin  <= sync_pin;
		end
	end

	assign pin_edge = sync_pin ^ prev_pin;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i)
			hold <= '0;
		else if (pin_edge)
			hold <= SENSE_HOLD; // Edge beats a same-cycle decay
		else if (dec_i && hold != '0)
			hold <= hold - SENSE_HOLD_W'(1);
	end

	assign sensed_o = (hold != '0);

endmodule

// ==== hw/pulse.sv ====
// Strobe generator; set CLOCKS_PER_PULSE to get a one-cycle pulse at that period
`timescale 1ns/1ps

module pulse #(
	parameter int CLOCKS_PER_PULSE = 12000
) (
	input  logic clock,
	input  logic rst_n_i,
	output logic pulse_o
);

	localparam int CNT_W = (CLOCKS_PER_PULSE > 1) ? $clog2(CLOCKS_PER_PULSE) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLOCKS_PER_PULSE - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count   <= RELOAD;
			pulse_o <= 1'b0;
		end else if (count == '0) begin
			count   <= RELOAD;
			pulse_o <= 1'b1; // First one lands CLOCKS_PER_PULSE after reset
		end else begin
			count   <= count - CNT_W'(1);
			pulse_o <= 1'b0;
		end
	end

endmodule

// ==== hw/uart_tx.sv ====
// 8N1 serial transmitter; accepts a byte when write is high and busy_o is low
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLOCKS_PER_BAUD = 104
) (
	input  logic                  clock,
	input  logic                  rst_n_i,
	input  bringup_pkg::uart_req_t req_i,
	output logic                  busy_o,
	output logic                  tx_o
);

	localparam int BAUD_W = (CLOCKS_PER_BAUD > 1) ? $clog2(CLOCKS_PER_BAUD) : 1;
	localparam logic [BAUD_W-1:0] BAUD_RELOAD = BAUD_W'(CLOCKS_PER_BAUD - 1);
	localparam logic [3:0]        STOP_BIT    = 4'd9;

	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0]        bit_idx;
	logic [8:0]        shift;   // Data bits then stop bit
	logic              accept;

	assign accept = req_i.write && !busy_o;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_o   <= 1'b0;
			tx_o     <= 1'b1; // Line idles high
			baud_cnt <= '0;
			bit_idx  <= '0;
		end else if (accept) begin
			busy_o   <= 1'b1;
			tx_o     <= 1'b0; // Start bit
			baud_cnt <= BAUD_RELOAD;
			bit_idx  <= '0;
		end else if (busy_o) begin
			if (baud_cnt != '0) begin
				baud_cnt <= baud_cnt - BAUD_W'(1);
			end else begin
				baud_cnt <= BAUD_RELOAD;
				if (bit_idx == STOP_BIT) begin
					busy_o <= 1'b0; // Stop bit has run its full length
				end else begin
					tx_o    <= shift[0];
					bit_idx <= bit_idx + 4'd1;
				end
			end
		end
	end

	// LSB first, fill with ones so the last bit out is the stop bit
	always_ff @(posedge clock) begin
		if (accept)
			shift <= {1'b1, req_i.data};
		else if (busy_o && baud_cnt == '0 && bit_idx != STOP_BIT)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

// ==== list.f ====
hw/bringup_pkg.sv
hw/pulse.sv
hw/bringup_driver.sv
hw/bringup_sensor.sv
hw/uart_tx.sv
hw/bringup_scanner.sv
hw/bringup_boundary.sv
verification/uart_rx_model.sv
verification/tb_bringup_boundary.sv

// ==== verification/tb_bringup_boundary.sv ====
// Testbench for the boundary checker; runs the stimulus table and checks every UART report line
`timescale 1ns/1ps

module tb_bringup_boundary;

	import bringup_pkg::*;

	localparam int NUM_PINS        = 8;
	localparam int DRIVE_CLOCKS    = 10;
	localparam int DEC_CLOCKS      = 100;
	localparam int SCAN_CLOCKS     = 1500;
	localparam int CLOCKS_PER_BAUD = 4;
	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int TOGGLE_CYCLES   = 7;
	localparam int NUM_ENTRIES     = 6;
	localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 3 * SCAN_CLOCKS + RESET_CYCLES;

	localparam uart_byte_t ASCII_ZERO = 8'h30;
	localparam uart_byte_t ASCII_ONE  = 8'h31;
	localparam uart_byte_t ASCII_CR   = 8'h0D;
	localparam uart_byte_t ASCII_LF   = 8'h0A;

	typedef struct packed {
		logic [NUM_PINS-1:0] mask; // Pins that toggle
		logic                loop; // drive_o feeds pin 0
		logic [NUM_PINS-1:0] live; // Pins expected to read '1'
	} entry_t;

	entry_t stim_table [NUM_ENTRIES] = '{
		'{mask: 8'hFF, loop: 1'b0, live: 8'hFF},
		'{mask: 8'h0F, loop: 1'b0, live: 8'h0F}, // Upper pins must decay
		'{mask: 8'h00, loop: 1'b1, live: 8'h01},
		'{mask: 8'hA5, loop: 1'b0, live: 8'hA5},
		'{mask: 8'h5A, loop: 1'b1, live: 8'h5B},
		'{mask: 8'h00, loop: 1'b0, live: 8'h00}
	};

	logic                clock;
	logic                rst_n_i;
	logic [NUM_PINS-1:0] pins;
	logic                drive;
	logic                uart_tx;
	logic [NUM_PINS-1:0] cur_mask;
	logic                cur_loop;
	logic [NUM_PINS-1:0] static_val;
	logic [NUM_PINS-1:0] toggle_val;
	logic                rx_valid;
	uart_byte_t          rx_data;
	logic                rx_start;
	logic                rx_stop;
	integer              seed;

	always_comb begin
		pins = (static_val & ~cur_mask) | (toggle_val & cur_mask);
		if (cur_loop)
			pins[0] = drive;
	end

	bringup_boundary #(
		.NUM_PINS        (NUM_PINS),
		.DRIVE_CLOCKS    (DRIVE_CLOCKS),
		.DEC_CLOCKS      (DEC_CLOCKS),
		.SCAN_CLOCKS     (SCAN_CLOCKS),
		.CLOCKS_PER_BAUD (CLOCKS_PER_BAUD)
	) UUT (
		.clock     (clock),
		.rst_n_i   (rst_n_i),
		.pins_i    (pins),
		.drive_o   (drive),
		.uart_tx_o (uart_tx)
	);

	uart_rx_model #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) rx_model (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.rx_i        (uart_tx),
		.valid_o     (rx_valid),
		.data_o      (rx_data),
		.start_bit_o (rx_start),
		.stop_bit_o  (rx_stop)
	);

	task automatic stop_on_error();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("[FAIL] %s: got %h expected %h", name, got, exp);
		stop_on_error();
	endtask

	// Waits for the next received frame and checks its framing
	task automatic get_byte(output uart_byte_t b);
		do
			@(posedge clock);
		while (!rx_valid);
		assert (rx_start == 1'b0) else value_error("uart_tx_o start bit", rx_start, 1'b0);
		assert (rx_stop == 1'b1) else value_error("uart_tx_o stop bit", rx_stop, 1'b1);
		b = rx_data;
	endtask

	task automatic skip_line();
		uart_byte_t b;
		int         n;
		n = 0;
		do begin
			get_byte(b);
			n++;
		end while (b != ASCII_LF && n < NUM_PINS + 2);
		assert (b == ASCII_LF) else value_error("uart_tx_o line end", b, ASCII_LF);
	endtask

	task automatic check_line(input entry_t e);
		uart_byte_t b;
		uart_byte_t exp;
		for (int i = 0; i < NUM_PINS; i++) begin
			get_byte(b);
			exp = e.live[i] ? ASCII_ONE : ASCII_ZERO;
			assert (b == exp) else value_error($sformatf("uart_tx_o pin %0d", i), b, exp);
		end
		get_byte(b);
		assert (b == ASCII_CR) else value_error("uart_tx_o CR", b, ASCII_CR);
		get_byte(b);
		assert (b == ASCII_LF) else value_error("uart_tx_o LF", b, ASCII_LF);
	endtask

	task automatic apply_entry(input entry_t e);
		int rand_word;
		@(posedge clock);
		#1;
		rand_word  = $random(seed);
		cur_mask   = e.mask;
		cur_loop   = e.loop;
		static_val = rand_word[NUM_PINS-1:0]; // Held for the whole entry
	endtask

	initial begin : clock_gen
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin : toggle_masked
		int count;
		toggle_val = '0;
		count      = 0;
		forever begin
			@(posedge clock);
			#1;
			count++;
			if (count == TOGGLE_CYCLES) begin
				count      = 0;
				toggle_val = ~toggle_val;
			end
		end
	end

	initial begin : run_table
		seed       = 32'h398;
		rst_n_i    = 1'b0;
		cur_mask   = '0;
		cur_loop   = 1'b0;
		static_val = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n_i = 1'b1;
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			apply_entry(stim_table[k]);
			skip_line(); // Snapshot may predate the change
			check_line(stim_table[k]);
		end
		$display("TEST PASSED");
		$finish;
	end

	// Line stays idle until the first scan pulse
	initial begin : idle_line
		@(posedge rst_n_i);
		repeat (SCAN_CLOCKS - 1) begin
			@(negedge clock);
			assert (uart_tx == 1'b1) else value_error("uart_tx_o before first scan", uart_tx, 1'b1);
		end
	end

	initial begin : drive_period
		int   count;
		logic last;
		logic seen_toggle;
		@(posedge rst_n_i);
		@(negedge clock);
		assert (drive == 1'b0) else value_error("drive_o after reset", drive, 1'b0);
		last        = drive;
		count       = 0;
		seen_toggle = 1'b0;
		forever begin
			@(negedge clock);
			count++;
			if (drive != last) begin
				if (seen_toggle)
					assert (count == DRIVE_CLOCKS) else value_error("drive_o half period", count, DRIVE_CLOCKS);
				seen_toggle = 1'b1;
				count       = 0;
				last        = drive;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the report lines did not arrive within %0d clock cycles", WATCHDOG_CYCLES);
		stop_on_error();
	end

endmodule

// ==== verification/uart_rx_model.sv ====
// Testbench UART receiver; samples each bit at mid-bit and hands the byte and its framing bits to the test
`timescale 1ns/1ps

module uart_rx_model #(
	parameter int CLOCKS_PER_BAUD = 104
) (
	input  logic                    clock,
	input  logic                    rst_n_i,
	input  logic                    rx_i,
	output logic                    valid_o,
	output bringup_pkg::uart_byte_t data_o,
	output logic                    start_bit_o,
	output logic                    stop_bit_o
);

	import bringup_pkg::*;

	logic       line_prev;
	logic       start_bit;
	uart_byte_t shift;

	// Works on falling clock edges so the outputs are stable at the rising edge
	initial begin
		valid_o     = 1'b0;
		data_o      = '0;
		start_bit_o = 1'b1;
		stop_bit_o  = 1'b1;
		line_prev   = 1'b1;
		forever begin
			@(negedge clock);
			valid_o = 1'b0;
			if (rst_n_i && line_prev && !rx_i) begin
				repeat (CLOCKS_PER_BAUD / 2) @(negedge clock); // Middle of start bit
				start_bit = rx_i;
				for (int i = 0; i < 8; i++) begin
					repeat (CLOCKS_PER_BAUD) @(negedge clock);
					shift[i] = rx_i; // LSB first
				end
				repeat (CLOCKS_PER_BAUD) @(negedge clock);
				data_o      = shift;
				start_bit_o = start_bit;
				stop_bit_o  = rx_i;
				valid_o     = 1'b1; // Held for one clock
			end
			line_prev = rx_i;
		end
	end

endmodule
